// File: noc_pkg.sv
/*
 * NoC link package
 * Flit format, default sizing of the virtual channel link and the
 * channel index width helper
 */
package noc_pkg;

  // Flit carried on the physical link
  // Destination tag in the upper bits, payload below
  typedef struct packed {
    logic [3:0]  dest;
    logic [15:0] payload;
  } flit_t;

  // Number of virtual channels sharing one physical channel
  localparam int unsigned NumVcDefault = 3;

  // Entries per input flit FIFO
  localparam int unsigned FifoDepthDefault = 4;

  // Downstream buffer slots per virtual channel
  localparam int unsigned MaxCreditsDefault = 4;

  // Width of an index over n entries
  // Never below 1 bit so a single channel still has a usable index
  function automatic int unsigned idx_width(input int unsigned n);
    int unsigned width;
    width = (n > 1) ? $clog2(n) : 1;
    return width;
  endfunction

endpackage

// File: vc_link_if.sv
/*
 * Arbiter to link stage connection
 * Winner flit and channel one way, credit state and accept the other way
 */
`timescale 1ns/1ps

interface vc_link_if import noc_pkg::*; #(
  parameter int unsigned NumVirtChannels = NumVcDefault,
  parameter type         flit_t          = logic
);

  localparam int unsigned IdxWidth = idx_width(NumVirtChannels);

  // Winner of the current cycle
  logic                       valid;
  flit_t                      flit;
  logic [IdxWidth-1:0]        vc;
  // Channel has at least one downstream slot
  logic [NumVirtChannels-1:0] credit_ok;
  // Link stage accepts the winner
  logic                       take;

  modport arbiter (output valid, flit, vc, input credit_ok, take);
  modport stage   (input valid, flit, vc, output credit_ok, take);

endinterface

// File: vc_flit_fifo.sv
/*
 * Virtual channel flit FIFO
 * Circular buffer with a valid/ready write side and a head-of-line
 * read side popped by the channel arbiter
 */
`timescale 1ns/1ps

module vc_flit_fifo #(
  parameter type         data_t = logic,
  parameter int unsigned Depth  = 4
) (
  input  logic  clk_i,
  input  logic  reset_i,
  // Write side
  input  logic  wr_valid_i,
  output logic  wr_ready_o,
  input  data_t wr_data_i,
  // Read side
  output logic  rd_valid_o,
  output data_t rd_data_o,
  input  logic  rd_pop_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  data_t [Depth-1:0]   mem;
  logic [PtrWidth-1:0] rd_ptr;
  logic [PtrWidth-1:0] wr_ptr;
  logic [CntWidth-1:0] count;
  logic                push;
  logic                pop;

  // Ready is the not-full flag and ignores the write valid
  assign wr_ready_o = (count != CntWidth'(Depth));
  assign rd_valid_o = (count != '0);
  assign rd_data_o  = mem[rd_ptr];

  assign push = wr_valid_i & wr_ready_o;
  assign pop  = rd_pop_i & rd_valid_o;

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PtrWidth'(Depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PtrWidth'(Depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy holds when push and pop coincide
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // Arbiter must only grant a channel whose FIFO holds a flit
  assert property (@(posedge clk_i) disable iff (reset_i) rd_pop_i |-> rd_valid_o);

  // Occupancy never passes Depth so a full FIFO takes no write
  assert property (@(posedge clk_i) disable iff (reset_i)
    count <= CntWidth'(Depth));

endmodule

// File: rr_arbiter.sv
/*
 * Round-robin arbiter
 * Grants one request per cycle starting at the pointer, muxes the
 * winner payload out and moves the pointer past the winner on advance
 */
`timescale 1ns/1ps

module rr_arbiter import noc_pkg::*; #(
  parameter int unsigned  NumIn    = 2,
  parameter type          data_t   = logic,
  localparam int unsigned IdxWidth = idx_width(NumIn)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic  [NumIn-1:0]   req_i,
  input  data_t [NumIn-1:0]   data_i,
  output logic  [NumIn-1:0]   gnt_o,
  output logic                valid_o,
  output data_t               data_o,
  output logic  [IdxWidth-1:0] idx_o,
  input  logic                advance_i
);

  // Highest priority position for the current cycle
  logic [IdxWidth-1:0] ptr;

  // Walk all inputs from the pointer upwards, wrapping around
  // First request found wins
  always_comb begin
    int unsigned cand;
    valid_o = 1'b0;
    idx_o   = '0;
    gnt_o   = '0;
    for (int unsigned i = 0; i < NumIn; i++) begin
      cand = int'(ptr) + i;
      if (cand >= NumIn) begin
        cand = cand - NumIn;
      end
      if (!valid_o && req_i[cand]) begin
        valid_o = 1'b1;
        idx_o   = IdxWidth'(cand);
      end
    end
    gnt_o[idx_o] = valid_o;
  end

  assign data_o = data_i[idx_o];

  // Pointer moves to the slot after the winner only when the grant is used
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr <= '0;
    end else if (advance_i && valid_o) begin
      if (idx_o == IdxWidth'(NumIn - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= idx_o + 1'b1;
      end
    end
  end

  // Grant is one-hot, lands on a request, and is empty without requests
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0) && ((|req_i) || (gnt_o == '0)));

endmodule

// File: vc_arbiter.sv
/*
 * Virtual channel arbiter
 * A channel competes when its FIFO holds a flit and the downstream
 * router has a free slot for it; one winner per cycle, round-robin
 */
`timescale 1ns/1ps

module vc_arbiter import noc_pkg::*; #(
  parameter int unsigned NumVirtChannels = NumVcDefault
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // Head of each channel FIFO
  input  logic  [NumVirtChannels-1:0]  fifo_valid_i,
  input  flit_t [NumVirtChannels-1:0]  fifo_flit_i,
  output logic  [NumVirtChannels-1:0]  fifo_pop_o,
  // Towards the link stage
  vc_link_if.arbiter                   link
);

  logic [NumVirtChannels-1:0] eligible;
  logic [NumVirtChannels-1:0] gnt;

  // Flit waiting and credit available, the valid-and-ready gating
  assign eligible = fifo_valid_i & link.credit_ok;

  rr_arbiter #(
    .NumIn  (NumVirtChannels),
    .data_t (flit_t)
  ) i_rr_arbiter (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (eligible),
    .data_i    (fifo_flit_i),
    .gnt_o     (gnt),
    .valid_o   (link.valid),
    .data_o    (link.flit),
    .idx_o     (link.vc),
    .advance_i (link.take)
  );

  // Pop only the granted FIFO, and only once the link stage takes it
  assign fifo_pop_o = gnt & {NumVirtChannels{link.take}};

endmodule

// File: vc_link_stage.sv
/*
 * Physical link output stage
 * Registers the winning flit and its channel onto the link and tracks
 * downstream buffer space with one credit counter per channel
 */
`timescale 1ns/1ps

module vc_link_stage import noc_pkg::*; #(
  parameter int unsigned  NumVirtChannels = NumVcDefault,
  parameter int unsigned  MaxCredits      = MaxCreditsDefault,
  localparam int unsigned IdxWidth        = idx_width(NumVirtChannels)
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  vc_link_if.stage                    link,
  // Credit return pulses from the downstream router
  input  logic [NumVirtChannels-1:0]  credit_i,
  // Physical link
  output logic                        out_valid_o,
  output flit_t                       out_flit_o,
  output logic [IdxWidth-1:0]         out_vc_o
);

  localparam int unsigned CntWidth = $clog2(MaxCredits + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t [NumVirtChannels-1:0] credits;
  logic                       xfer;

  // No back-pressure on the link, the arbiter already filtered on credit
  assign link.take = link.valid;
  assign xfer      = link.valid & link.take;

  for (genvar c = 0; c < NumVirtChannels; c++) begin : gen_credit
    logic dec;

    assign dec = xfer && (link.vc == IdxWidth'(c));

    // Send and return in the same cycle cancel out
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        credits[c] <= cnt_t'(MaxCredits);
      end else if (dec && !credit_i[c]) begin
        credits[c] <= credits[c] - 1'b1;
      end else if (credit_i[c] && !dec) begin
        credits[c] <= credits[c] + 1'b1;
      end
    end

    assign link.credit_ok[c] = (credits[c] != '0);

    // Downstream never returns more credits than it has slots
    assert property (@(posedge clk_i) disable iff (reset_i)
      credits[c] <= cnt_t'(MaxCredits));

    // Arbiter never sends on a channel that is out of credit
    assert property (@(posedge clk_i) disable iff (reset_i)
      dec |-> (credits[c] != '0));
  end

  // Link valid lasts one cycle per transferred flit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= xfer;
    end
  end

  // Flit and channel number only load on a transfer
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      out_flit_o <= link.flit;
      out_vc_o   <= link.vc;
    end
  end

endmodule

// File: noc_vc_link_top.sv
/*
 * Virtual channel link top level
 * Per-channel input FIFOs, round-robin channel arbiter and the
 * credit-based link output stage
 */
`timescale 1ns/1ps

module noc_vc_link_top import noc_pkg::*; #(
  parameter int unsigned  NumVirtChannels = NumVcDefault,
  parameter int unsigned  FifoDepth       = FifoDepthDefault,
  parameter int unsigned  MaxCredits      = MaxCreditsDefault,
  localparam int unsigned IdxWidth        = idx_width(NumVirtChannels)
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // Per-channel input
  input  logic  [NumVirtChannels-1:0]  in_valid_i,
  output logic  [NumVirtChannels-1:0]  in_ready_o,
  input  flit_t [NumVirtChannels-1:0]  in_flit_i,
  // Credit return from downstream
  input  logic  [NumVirtChannels-1:0]  credit_i,
  // Physical link
  output logic                         out_valid_o,
  output flit_t                        out_flit_o,
  output logic  [IdxWidth-1:0]         out_vc_o
);

  logic  [NumVirtChannels-1:0] fifo_valid;
  logic  [NumVirtChannels-1:0] fifo_pop;
  flit_t [NumVirtChannels-1:0] fifo_flit;

  vc_link_if #(
    .NumVirtChannels (NumVirtChannels),
    .flit_t          (flit_t)
  ) link ();

  // One FIFO per virtual channel
  for (genvar c = 0; c < NumVirtChannels; c++) begin : gen_fifo
    vc_flit_fifo #(
      .data_t (flit_t),
      .Depth  (FifoDepth)
    ) i_fifo (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wr_valid_i (in_valid_i[c]),
      .wr_ready_o (in_ready_o[c]),
      .wr_data_i  (in_flit_i[c]),
      .rd_valid_o (fifo_valid[c]),
      .rd_data_o  (fifo_flit[c]),
      .rd_pop_i   (fifo_pop[c])
    );
  end

  vc_arbiter #(
    .NumVirtChannels (NumVirtChannels)
  ) i_vc_arbiter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fifo_valid_i (fifo_valid),
    .fifo_flit_i  (fifo_flit),
    .fifo_pop_o   (fifo_pop),
    .link         (link.arbiter)
  );

  vc_link_stage #(
    .NumVirtChannels (NumVirtChannels),
    .MaxCredits      (MaxCredits)
  ) i_vc_link_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .link        (link.stage),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o),
    .out_vc_o    (out_vc_o)
  );

endmodule

// File: tb_noc_vc_link.sv
/*
 * Testbench for the virtual channel link
 * Table-driven stimulus, per-channel reference queues, a credit model
 * and a round-robin model predict every output of the DUT
 */
`timescale 1ns/1ps

module tb_noc_vc_link
  import noc_pkg::*;
();

  localparam int unsigned NumVc   = NumVcDefault;
  localparam int unsigned Depth   = FifoDepthDefault;
  localparam int          MaxCred = MaxCreditsDefault;
  localparam int unsigned IdxW    = idx_width(NumVc);
  localparam int          NumRows = 6;

  // Row kinds select the extra checks of a test
  localparam logic [1:0] KindPlain  = 2'd0;
  localparam logic [1:0] KindDrain  = 2'd1;
  localparam logic [1:0] KindFair   = 2'd2;
  localparam logic [1:0] KindStarve = 2'd3;

  typedef struct packed {
    logic [NumVc-1:0] wr_mask;
    logic [NumVc-1:0] cr_mask;
    logic [7:0]       hold;
    logic [1:0]       kind;
  } row_t;

  logic                    clk_i;
  logic                    reset_i;
  logic  [NumVc-1:0]       in_valid_i;
  logic  [NumVc-1:0]       in_ready_o;
  flit_t [NumVc-1:0]       in_flit_i;
  logic  [NumVc-1:0]       credit_i;
  logic                    out_valid_o;
  flit_t                   out_flit_o;
  logic  [IdxW-1:0]        out_vc_o;

  row_t         rows [NumRows];
  string        row_names [NumRows];
  flit_t        model_q [NumVc][$];
  int           model_cred [NumVc];
  int           model_ptr;
  logic         exp_valid;
  flit_t        exp_flit;
  int           exp_vc;
  logic [31:0]  lcg_state;
  int           error_count;
  int           pass_count;
  int           fail_count;
  int           cycle_count;
  int           cycle_limit;

  noc_vc_link_top UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_flit_i   (in_flit_i),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o),
    .out_vc_o    (out_vc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Hard stop in case the DUT never drains
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles without finishing", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Tag carries the channel and the payload is pseudo random
  function automatic flit_t make_flit(input int c);
    flit_t f;
    logic [31:0] r;
    r         = lcg_next();
    f.dest    = 4'(c);
    f.payload = r[23:8];
    return f;
  endfunction

  // FIFO has room while fewer than Depth flits wait
  function automatic logic [NumVc-1:0] model_ready();
    logic [NumVc-1:0] rdy;
    for (int c = 0; c < NumVc; c++) begin
      rdy[c] = (model_q[c].size() < Depth);
    end
    return rdy;
  endfunction

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic load_table();
    rows[0] = '{wr_mask: 3'b111, cr_mask: 3'b111, hold: 8'd3,  kind: KindPlain};
    rows[1] = '{wr_mask: 3'b000, cr_mask: 3'b111, hold: 8'd12, kind: KindDrain};
    rows[2] = '{wr_mask: 3'b111, cr_mask: 3'b111, hold: 8'd12, kind: KindFair};
    rows[3] = '{wr_mask: 3'b000, cr_mask: 3'b111, hold: 8'd20, kind: KindDrain};
    rows[4] = '{wr_mask: 3'b111, cr_mask: 3'b110, hold: 8'd16, kind: KindStarve};
    rows[5] = '{wr_mask: 3'b000, cr_mask: 3'b111, hold: 8'd25, kind: KindDrain};
    row_names[0] = "channel order";
    row_names[1] = "order drain";
    row_names[2] = "round-robin fairness";
    row_names[3] = "fairness drain";
    row_names[4] = "credit limit and back-pressure";
    row_names[5] = "credit resume";
  endtask

  // Compare the DUT at a falling edge against the model state
  task automatic check_outputs();
    assert (out_valid_o === exp_valid) else
      report_error($sformatf("out_valid_o is %b, expected %b", out_valid_o, exp_valid));
    if (exp_valid && out_valid_o === 1'b1) begin
      assert (int'(out_vc_o) == exp_vc) else
        report_error($sformatf("out_vc_o is %0d, expected %0d", out_vc_o, exp_vc));
      assert (out_flit_o === exp_flit) else
        report_error($sformatf("out_flit_o is %h, expected %h", out_flit_o, exp_flit));
    end
    assert (in_ready_o === model_ready()) else
      report_error($sformatf("in_ready_o is %b, expected %b", in_ready_o, model_ready()));
  endtask

  // Drive one cycle, predict the next rising edge, then check
  task automatic step_cycle(input logic [NumVc-1:0] wr_mask, input logic [NumVc-1:0] cr_mask);
    logic [NumVc-1:0] ready;
    logic [NumVc-1:0] elig;
    logic             got;
    int               win;
    int               cand;
    ready = model_ready();
    got   = 1'b0;
    win   = 0;
    for (int c = 0; c < NumVc; c++) begin
      elig[c] = (model_q[c].size() > 0) && (model_cred[c] > 0);
      // Downstream only returns slots that hold a flit
      credit_i[c] = cr_mask[c] && (model_cred[c] < MaxCred);
      // A refused flit stays on the bus until it is taken
      if (wr_mask[c] && !(in_valid_i[c] && !in_ready_o[c])) begin
        in_flit_i[c] = make_flit(c);
      end
      in_valid_i[c] = wr_mask[c];
    end
    // Lowest eligible channel at or above the pointer with wrap-around
    for (int i = 0; i < NumVc; i++) begin
      cand = (model_ptr + i) % NumVc;
      if (!got && elig[cand]) begin
        got = 1'b1;
        win = cand;
      end
    end
    exp_valid = got;
    if (got) begin
      exp_flit  = model_q[win].pop_front();
      exp_vc    = win;
      model_ptr = (win + 1) % NumVc;
    end
    for (int c = 0; c < NumVc; c++) begin
      if (got && win == c) begin
        model_cred[c]--;
      end
      if (credit_i[c]) begin
        model_cred[c]++;
      end
      if (wr_mask[c] && ready[c]) begin
        model_q[c].push_back(in_flit_i[c]);
      end
    end
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      pass_count++;
      $display("Test %s passed", name);
    end else begin
      fail_count++;
      $display("Test %s failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  initial begin
    int errs_before;
    int total_cycles;
    int sent_ch0;
    int sent_all;
    int last_vc;
    logic have_last;
    logic saw_full;
    reset_i     = 1'b1;
    in_valid_i  = '0;
    in_flit_i   = '0;
    credit_i    = '0;
    lcg_state   = 32'hafd7;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    cycle_count = 0;
    load_table();
    total_cycles = 0;
    for (int r = 0; r < NumRows; r++) begin
      total_cycles += int'(rows[r].hold);
    end
    cycle_limit = 4 * total_cycles + 100;
    // Model starts in the reset state
    for (int c = 0; c < NumVc; c++) begin
      model_cred[c] = MaxCred;
    end
    model_ptr = 0;
    exp_valid = 1'b0;
    exp_flit  = '0;
    exp_vc    = 0;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    errs_before = error_count;
    assert (out_valid_o === 1'b0) else
      report_error($sformatf("out_valid_o is %b after reset", out_valid_o));
    assert (in_ready_o === {NumVc{1'b1}}) else
      report_error($sformatf("in_ready_o is %b after reset", in_ready_o));
    finish_test("reset state", errs_before);

    for (int r = 0; r < NumRows; r++) begin
      errs_before = error_count;
      sent_ch0    = 0;
      sent_all    = 0;
      last_vc     = 0;
      have_last   = 1'b0;
      saw_full    = 1'b0;
      for (int k = 0; k < int'(rows[r].hold); k++) begin
        step_cycle(rows[r].wr_mask, rows[r].cr_mask);
        if (out_valid_o === 1'b1) begin
          // All channels backlogged, so the winner steps by one each flit
          if (rows[r].kind == KindFair && have_last) begin
            assert (int'(out_vc_o) == (last_vc + 1) % NumVc) else
              report_error($sformatf("out_vc_o %0d does not follow %0d", out_vc_o, last_vc));
          end
          last_vc   = int'(out_vc_o);
          have_last = 1'b1;
          sent_all++;
          if (out_vc_o == '0) begin
            sent_ch0++;
          end
        end
        if (in_ready_o[0] === 1'b0) begin
          saw_full = 1'b1;
        end
      end
      if (rows[r].kind == KindStarve) begin
        assert (sent_ch0 <= MaxCred) else
          report_error($sformatf("channel 0 sent %0d flits without credit return", sent_ch0));
        assert (sent_all > sent_ch0) else
          report_error("other channels stopped while channel 0 was out of credit");
        assert (saw_full) else
          report_error("channel 0 input never showed back-pressure");
      end
      if (rows[r].kind == KindDrain) begin
        for (int c = 0; c < NumVc; c++) begin
          assert (model_q[c].size() == 0) else
            report_error($sformatf("channel %0d still has %0d flits queued", c,
                                   model_q[c].size()));
        end
      end
      finish_test(row_names[r], errs_before);
    end

    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
noc_pkg.sv
vc_link_if.sv
vc_flit_fifo.sv
rr_arbiter.sv
vc_arbiter.sv
vc_link_stage.sv
noc_vc_link_top.sv
tb_noc_vc_link.sv
